//--- zports_pkg.sv
// Shared definitions for the Z80 I/O port block.
// Port addresses, extension sub-addresses and the structs passed between blocks.

package zports_pkg;

	////////////////////////////////////////////////////////////////////////////
	// low address byte of the internal ports
	localparam logic [7:0] PORT_FE = 8'hFE;	// border, keyboard, tape
	localparam logic [7:0] PORT_XT = 8'hAF;	// extension ports #nnAF
	localparam logic [7:0] PORT_FD = 8'hFD;	// 7FFD paging, AY above
	localparam logic [7:0] PORT_F7 = 8'hF7;	// EFF7
	localparam logic [7:0] PORT_BE = 8'hBE;	// config readback
	localparam logic [7:0] PORT_BF = 8'hBF;	// shadow enable

	////////////////////////////////////////////////////////////////////////////
	// #nnAF sub-addresses, taken from the high address byte
	localparam logic [7:0] XT_VCONF   = 8'h00;
	localparam logic [7:0] XT_VPAGE   = 8'h01;
	localparam logic [7:0] XT_XOFFSL  = 8'h02;
	localparam logic [7:0] XT_XOFFSH  = 8'h03;	// bit 0 only
	localparam logic [7:0] XT_YOFFSL  = 8'h04;
	localparam logic [7:0] XT_YOFFSH  = 8'h05;	// bit 0 only
	localparam logic [7:0] XT_TSCONF  = 8'h06;
	localparam logic [7:0] XT_PALSEL  = 8'h07;
	localparam logic [7:0] XT_BORDER  = 8'h0F;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_HSINT   = 8'h22;
	localparam logic [7:0] XT_VSINTL  = 8'h23;
	localparam logic [7:0] XT_VSINTH  = 8'h24;	// bit 0 only
	localparam logic [7:0] XT_IM2VECT = 8'h25;
	localparam logic [7:0] XT_STAT    = 8'h00;	// read side of sub-address 00

	// pentagon line for the horizontal interrupt
	localparam logic [7:0] HINT_PENTAGON = 8'd2;

	// decoded port
	typedef enum logic [3:0] {
		SEL_NONE,
		SEL_FE,
		SEL_XT,
		SEL_FD,
		SEL_F7,
		SEL_BE,
		SEL_BF,
		SEL_XSTAT_RO	// #00AF, status on read
	} port_sel_t;

	// one write event from the strobe and decode stage
	typedef struct packed {
		port_sel_t  sel;
		logic [7:0] hoa;	// high address byte
		logic [7:0] data;
		logic       wr;		// single zclk pulse
	} io_wr_t;

	typedef struct packed {
		logic [7:0] vconf;
		logic [7:0] vpage;
		logic [8:0] x_offs;
		logic [8:0] y_offs;
		logic [7:0] tsconf;
		logic [3:0] palsel;
		logic [7:0] sysconf;
		logic [7:0] memconf;
		logic [7:0] hint_beg;
		logic [8:0] vint_beg;
		logic [7:0] im2vect;
	} xt_cfg_t;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;
		logic [5:0] pent1m_page;	// full 1M page number
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
		logic       shadow;
	} page_cfg_t;

endpackage

//--- bus_strobe.sv
// Turns the asynchronous Z80 I/O request lines into single zclk pulses.
// One write or read pulse per bus cycle, on the second edge that sees it.

`timescale 1ns/1ns

module bus_strobe (
	input  logic zclk,
	input  logic rst_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr;	// live bus requests
	logic iord;
	logic iowr_cur;
	logic iord_cur;
	logic iowr_prev;
	logic iord_prev;

	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);

	// first edge samples, second edge compares against the older sample
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_cur  <= 1'b0;
			iord_cur  <= 1'b0;
			iowr_prev <= 1'b0;
			iord_prev <= 1'b0;
			port_wr   <= 1'b0;
			port_rd   <= 1'b0;
		end
		else
		begin
			iowr_cur  <= iowr;
			iord_cur  <= iord;
			iowr_prev <= iowr_cur;
			iord_prev <= iord_cur;
			port_wr   <= iowr_cur & ~iowr_prev;	// rising edge of write
			port_rd   <= iord_cur & ~iord_prev;
		end
	end

	// a bus cycle is either a read or a write
	a_no_rd_wr_overlap: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

//--- port_decode.sv
// Combinational port decode from the 16-bit Z80 address.
// Gives the selected internal port, the hit flag and the external AY flag.

`timescale 1ns/1ns

module port_decode (
	input  logic [15:0]           a,
	input  logic                  shadow,
	output zports_pkg::port_sel_t sel,
	output logic                  porthit,
	output logic                  external_port
);

	import zports_pkg::*;

	logic [7:0] loa;
	logic [7:0] hoa;

	assign loa = a[7:0];
	assign hoa = a[15:8];

	always_comb
	begin
		case (loa)
			PORT_FE:
				sel = SEL_FE;
			PORT_XT:
			begin
				// status read shares sub-address 00
				if (hoa == XT_STAT)
					sel = SEL_XSTAT_RO;
				else
					sel = SEL_XT;
			end
			PORT_FD:
				sel = SEL_FD;
			PORT_F7:
			begin
				// xFF7 family normally, xEF7 style (a8 = 0) in shadow mode
				if (a[8] ^ shadow)
					sel = SEL_F7;
				else
					sel = SEL_NONE;
			end
			PORT_BE:
				sel = SEL_BE;
			PORT_BF:
				sel = SEL_BF;
			default:
				sel = SEL_NONE;
		endcase
	end

	assign porthit = (sel != SEL_NONE);

	// #FFFD/#BFFD belong to the AY chip
	assign external_port = (sel == SEL_FD) & a[15];

endmodule

//--- xt_regs.sv
// Extension port #nnAF register file and the border register.
// Loads on the write pulse; vpage also follows accepted 7FFD writes.

`timescale 1ns/1ns

module xt_regs #(
	parameter logic [7:0] HINT_DEFAULT = zports_pkg::HINT_PENTAGON
) (
	input  logic                zclk,
	input  logic                rst_n,
	input  zports_pkg::io_wr_t  io,
	input  logic                p7ffd_wr,
	input  logic [7:0]          p7ffd_data,
	output zports_pkg::xt_cfg_t cfg,
	output logic [7:0]          border
);

	import zports_pkg::*;

	logic xt_wr;
	logic fe_wr;

	// sub-address 00 decodes as status for reads, writes still hit vconf
	assign xt_wr = io.wr & ((io.sel == SEL_XT) | (io.sel == SEL_XSTAT_RO));
	assign fe_wr = io.wr & (io.sel == SEL_FE);

	////////////////////////////////////////////////////////////////////////////
	// config registers
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			cfg.vconf    <= 8'h00;
			cfg.vpage    <= 8'h05;	// screen in page 5
			cfg.x_offs   <= 9'd0;
			cfg.y_offs   <= 9'd0;
			cfg.tsconf   <= 8'h00;
			cfg.palsel   <= 4'hF;
			cfg.sysconf  <= 8'h00;
			cfg.memconf  <= 8'h00;
			cfg.hint_beg <= HINT_DEFAULT;
			cfg.vint_beg <= 9'd0;
			cfg.im2vect  <= 8'hFF;
		end
		else
		begin
			if (p7ffd_wr)
				cfg.vpage <= {6'b000001, p7ffd_data[3], 1'b1};	// page 5 or 7
			else if (xt_wr && io.hoa == XT_VPAGE)
				cfg.vpage <= io.data;

			if (xt_wr)
			begin
				case (io.hoa)
					XT_VCONF:   cfg.vconf          <= io.data;
					XT_XOFFSL:  cfg.x_offs[7:0]    <= io.data;
					XT_XOFFSH:  cfg.x_offs[8]      <= io.data[0];
					XT_YOFFSL:  cfg.y_offs[7:0]    <= io.data;
					XT_YOFFSH:  cfg.y_offs[8]      <= io.data[0];
					XT_TSCONF:  cfg.tsconf         <= io.data;
					XT_PALSEL:  cfg.palsel         <= io.data[3:0];
					XT_SYSCONF: cfg.sysconf        <= io.data;
					XT_MEMCONF: cfg.memconf        <= io.data;
					XT_HSINT:   cfg.hint_beg       <= io.data;
					XT_VSINTL:  cfg.vint_beg[7:0]  <= io.data;
					XT_VSINTH:  cfg.vint_beg[8]    <= io.data[0];
					XT_IM2VECT: cfg.im2vect        <= io.data;
					default:    ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// border, #FE gives the 8 spectrum colours, #0FAF the full index
	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			border <= 8'h00;
		else if (fe_wr)
			border <= {5'b11110, io.data[2:0]};
		else if (xt_wr && io.hoa == XT_BORDER)
			border <= io.data;
	end

endmodule

//--- pager_regs.sv
// 128K/1M paging registers behind #7FFD and #EFF7, plus the #BF shadow bit.
// p7ffd_wr flags an accepted 7FFD write to the other register blocks.

`timescale 1ns/1ns

module pager_regs (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  zports_pkg::io_wr_t    io,
	input  logic                  a15,
	input  logic                  a12,
	output zports_pkg::page_cfg_t cfg,
	output logic                  p7ffd_wr
);

	import zports_pkg::*;

	logic [7:0] p7ffd;
	logic [7:0] peff7;
	logic [5:0] pent1m_page;
	logic       lock;	// 7FFD frozen until reset
	logic       shadow;
	logic       block1m;

	assign block1m  = peff7[2];	// 128K mode, no 1M extension
	assign p7ffd_wr = io.wr & (io.sel == SEL_FD) & ~a15 & ~lock;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd       <= 8'h00;
			peff7       <= 8'h00;
			pent1m_page <= 6'd0;
			lock        <= 1'b0;
			shadow      <= 1'b0;
		end
		else
		begin
			if (p7ffd_wr)
			begin
				p7ffd       <= io.data;
				lock        <= io.data[5] & block1m;
				pent1m_page <= {block1m ? 3'b000 : {io.data[5], io.data[7:6]}, io.data[2:0]};
			end
			if (io.wr && io.sel == SEL_F7 && !shadow && !a12)	// EFF7
				peff7 <= io.data;
			if (io.wr && io.sel == SEL_BF)
				shadow <= io.data[0];
		end
	end

	always_comb
	begin
		cfg.p7ffd         = p7ffd;
		cfg.peff7         = peff7;
		cfg.pent1m_page   = pent1m_page;
		cfg.pent1m_rom    = p7ffd[4];
		cfg.pent1m_1m_on  = ~block1m;
		cfg.pent1m_ram0_0 = peff7[3];
		cfg.shadow        = shadow;
	end

	// once locked, paging stays frozen and no later 7FFD write gets through
	a_lock_holds: assert property (@(posedge zclk) disable iff (!rst_n)
		lock |=> (lock && !p7ffd_wr && $stable(p7ffd)));

endmodule

//--- read_mux.sv
// Read-back byte for the CPU and the data bus claim.
// Purely combinational from the decoded port and the current bus state.

`timescale 1ns/1ns

module read_mux (
	input  zports_pkg::port_sel_t sel,
	input  logic [7:0]            hoa,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  porthit,
	input  logic                  external_port,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic                  dma_act,
	input  logic [7:0]            ramnroms,
	input  logic [7:0]            dos7ffds,
	input  zports_pkg::page_cfg_t page,
	output logic [7:0]            dout,
	output logic                  dataout
);

	import zports_pkg::*;

	logic [7:0] be_mux;	// #xxBE config readback, a[11:8]

	always_comb
	begin
		case (hoa[3:0])
			4'h8:    be_mux = ramnroms;
			4'h9:    be_mux = dos7ffds;
			4'hA:    be_mux = page.p7ffd;
			4'hB:    be_mux = page.peff7;
			default: be_mux = 8'hFF;
		endcase
	end

	always_comb
	begin
		case (sel)
			SEL_FE:       dout = {1'b1, tape_read, 1'b0, keys_in};
			SEL_XSTAT_RO: dout = {dma_act, 7'b0000000};
			SEL_BF:       dout = {4'b0000, 1'b0, 1'b0, 1'b0, page.shadow};
			SEL_BE:       dout = be_mux;
			default:      dout = 8'hFF;	// other #AF sub-addresses too
		endcase
	end

	// drive the bus only for our own ports, never for the AY
	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

endmodule

//--- zports_top.sv
// Top of the Z80 I/O port block.
// Strobes, decode, register blocks and read mux wired together.

`timescale 1ns/1ns

module zports_top #(
	parameter logic [7:0] HINT_DEFAULT = zports_pkg::HINT_PENTAGON
) (
	input  logic                  zclk,
	input  logic                  rst_n,
	input  logic [15:0]           a,
	input  logic [7:0]            din,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic                  dma_act,
	input  logic [7:0]            ramnroms,
	input  logic [7:0]            dos7ffds,
	output logic [7:0]            dout,
	output logic                  dataout,
	output logic                  porthit,
	output logic                  external_port,
	output logic [7:0]            border,
	output zports_pkg::xt_cfg_t   xt_cfg,
	output zports_pkg::page_cfg_t page_cfg,
	output logic                  p7ffd_wr
);

	import zports_pkg::*;

	logic      port_wr;
	port_sel_t sel;
	io_wr_t    io;

	assign io = '{sel: sel, hoa: a[15:8], data: din, wr: port_wr};

	// no read side effects here, the read strobe stays open
	bus_strobe u_strobe (.zclk(zclk), .rst_n(rst_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .port_wr(port_wr), .port_rd());

	port_decode u_decode (.a(a), .shadow(page_cfg.shadow), .sel(sel), .porthit(porthit),
		.external_port(external_port));

	xt_regs #(.HINT_DEFAULT(HINT_DEFAULT)) u_xt (.zclk(zclk), .rst_n(rst_n), .io(io),
		.p7ffd_wr(p7ffd_wr), .p7ffd_data(din), .cfg(xt_cfg), .border(border));

	pager_regs u_pager (.zclk(zclk), .rst_n(rst_n), .io(io), .a15(a[15]), .a12(a[12]),
		.cfg(page_cfg), .p7ffd_wr(p7ffd_wr));

	read_mux u_rmux (.sel(sel), .hoa(a[15:8]), .iorq_n(iorq_n), .rd_n(rd_n),
		.porthit(porthit), .external_port(external_port), .keys_in(keys_in),
		.tape_read(tape_read), .dma_act(dma_act), .ramnroms(ramnroms),
		.dos7ffds(dos7ffds), .page(page_cfg), .dout(dout), .dataout(dataout));

endmodule

//--- tb_zports.sv
// Testbench for the Z80 I/O port block, run from the project root.
// Drives Z80 I/O bus cycles and checks the DUT against a model of the port rules.

`timescale 1ns/1ns

module tb_zports;

	import zports_pkg::*;

	typedef logic [127:0] wide_t;

	localparam int CLK_PERIOD     = 20;
	localparam int BUS_CYCLES     = 200;	// upper bound on bus cycles in the run
	localparam int CLKS_PER_CYCLE = 8;
	localparam logic [7:0] HINT_VAL = 8'h07;

	localparam logic [7:0] XT_LIST [15] = '{XT_VCONF, XT_VPAGE, XT_XOFFSL, XT_XOFFSH,
		XT_YOFFSL, XT_YOFFSH, XT_TSCONF, XT_PALSEL, XT_BORDER, XT_SYSCONF, XT_MEMCONF,
		XT_HSINT, XT_VSINTL, XT_VSINTH, XT_IM2VECT};

	logic        zclk = 1'b0;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic        dma_act;
	logic [7:0]  ramnroms;
	logic [7:0]  dos7ffds;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;
	logic [7:0]  border;
	xt_cfg_t     xt_cfg;
	page_cfg_t   page_cfg;
	logic        p7ffd_wr;

	int seed = 32'hb32dcdcc;
	int err_cnt = 0;
	int pulse_cnt = 0;

	// model state
	xt_cfg_t    m_xt;
	page_cfg_t  m_page;
	logic [7:0] m_border;
	logic       m_lock;

	zports_top #(.HINT_DEFAULT(HINT_VAL)) dut (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .keys_in(keys_in), .tape_read(tape_read),
		.dma_act(dma_act), .ramnroms(ramnroms), .dos7ffds(dos7ffds), .dout(dout),
		.dataout(dataout), .porthit(porthit), .external_port(external_port), .border(border),
		.xt_cfg(xt_cfg), .page_cfg(page_cfg), .p7ffd_wr(p7ffd_wr));

	always #(CLK_PERIOD / 2) zclk = ~zclk;

	// pulse is stable across the falling edge
	always @(negedge zclk)
		if (rst_n && p7ffd_wr)
			pulse_cnt++;

	////////////////////////////////////////////////////////////////////////////
	// reporting

	task automatic fail_stop;
		begin
			err_cnt++;
			$display("Errors found");
			$fatal(1, "run stopped at the first failure");
		end
	endtask

	task automatic check_val(input string name, input wide_t exp_v, input wide_t act_v);
		begin
			assert (act_v === exp_v)
			else
			begin
				$display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
				fail_stop();
			end
		end
	endtask

	a_pulse_single: assert property (@(posedge zclk) disable iff (!rst_n)
		p7ffd_wr |=> !p7ffd_wr)
	else
	begin
		$display("p7ffd_wr stayed high for more than one clock");
		fail_stop();
	end

	a_no_claim_external: assert property (@(posedge zclk) disable iff (!rst_n)
		dataout |-> (!external_port && !iorq_n && !rd_n))
	else
	begin
		$display("dataout claimed the bus outside an internal port read");
		fail_stop();
	end

	////////////////////////////////////////////////////////////////////////////
	// model of the port rules

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		begin
			r = $random(seed);
			rand_byte = r[7:0];
		end
	endfunction

	function automatic int pick_hold();
		pick_hold = 2 + int'($unsigned($random(seed)) % 4);	// 2 to 5 clocks
	endfunction

	function automatic logic f7_hit(input logic [15:0] addr);
		f7_hit = m_page.shadow ? !addr[8] : addr[8];
	endfunction

	function automatic logic exp_hit(input logic [15:0] addr);
		case (addr[7:0])
			PORT_FE, PORT_XT, PORT_FD, PORT_BE, PORT_BF: exp_hit = 1'b1;
			PORT_F7: exp_hit = f7_hit(addr);
			default: exp_hit = 1'b0;
		endcase
	endfunction

	function automatic logic [7:0] exp_read(input logic [15:0] addr);
		logic [7:0] hi;
		begin
			hi = addr[15:8];
			exp_read = 8'hFF;
			if (addr[7:0] == PORT_FE)
				exp_read = {1'b1, tape_read, 1'b0, keys_in};
			else if (addr[7:0] == PORT_XT && hi == XT_STAT)
				exp_read = {dma_act, 7'b0000000};
			else if (addr[7:0] == PORT_BF)
				exp_read = {7'b0000000, m_page.shadow};
			else if (addr[7:0] == PORT_BE)
			begin
				case (hi[3:0])
					4'h8:    exp_read = ramnroms;
					4'h9:    exp_read = dos7ffds;
					4'hA:    exp_read = m_page.p7ffd;
					4'hB:    exp_read = m_page.peff7;
					default: exp_read = 8'hFF;
				endcase
			end
		end
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] d);
		begin
			case (addr[7:0])
				PORT_FE: m_border = {5'b11110, d[2:0]};
				PORT_XT:
				begin
					case (addr[15:8])
						XT_VCONF:   m_xt.vconf = d;
						XT_VPAGE:   m_xt.vpage = d;
						XT_XOFFSL:  m_xt.x_offs[7:0] = d;
						XT_XOFFSH:  m_xt.x_offs[8] = d[0];
						XT_YOFFSL:  m_xt.y_offs[7:0] = d;
						XT_YOFFSH:  m_xt.y_offs[8] = d[0];
						XT_TSCONF:  m_xt.tsconf = d;
						XT_PALSEL:  m_xt.palsel = d[3:0];
						XT_BORDER:  m_border = d;
						XT_SYSCONF: m_xt.sysconf = d;
						XT_MEMCONF: m_xt.memconf = d;
						XT_HSINT:   m_xt.hint_beg = d;
						XT_VSINTL:  m_xt.vint_beg[7:0] = d;
						XT_VSINTH:  m_xt.vint_beg[8] = d[0];
						XT_IM2VECT: m_xt.im2vect = d;
						default:    ;
					endcase
				end
				PORT_FD:
				begin
					if (!addr[15] && !m_lock)	// accepted 7FFD write
					begin
						m_page.pent1m_page = {m_page.peff7[2] ? 3'b000 : {d[5], d[7:6]}, d[2:0]};
						m_lock = d[5] & m_page.peff7[2];
						m_page.p7ffd = d;
						m_xt.vpage = {6'b000001, d[3], 1'b1};
					end
				end
				PORT_F7:
					if (f7_hit(addr) && !m_page.shadow && !addr[12])
						m_page.peff7 = d;
				PORT_BF: m_page.shadow = d[0];
				default: ;
			endcase
		end
	endtask

	task automatic check_state(input string name);
		begin
			check_val({name, " xt_cfg"}, wide_t'(m_xt), wide_t'(xt_cfg));
			check_val({name, " border"}, wide_t'(m_border), wide_t'(border));
			check_val({name, " p7ffd"}, wide_t'(m_page.p7ffd), wide_t'(page_cfg.p7ffd));
			check_val({name, " peff7"}, wide_t'(m_page.peff7), wide_t'(page_cfg.peff7));
			check_val({name, " 1m page"}, wide_t'(m_page.pent1m_page),
				wide_t'(page_cfg.pent1m_page));
			check_val({name, " 1m rom"}, wide_t'(m_page.p7ffd[4]), wide_t'(page_cfg.pent1m_rom));
			check_val({name, " 1m on"}, wide_t'(!m_page.peff7[2]),
				wide_t'(page_cfg.pent1m_1m_on));
			check_val({name, " ram0 0"}, wide_t'(m_page.peff7[3]),
				wide_t'(page_cfg.pent1m_ram0_0));
			check_val({name, " shadow"}, wide_t'(m_page.shadow), wide_t'(page_cfg.shadow));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Z80 bus cycles

	task automatic bus_write(input string name, input logic [15:0] addr, input logic [7:0] data,
		input int hold);
		int n;
		int pulses_before;
		logic exp_pulse;
		begin
			n = (hold > 0) ? hold : pick_hold();
			@(negedge zclk);
			a = addr;
			din = data;
			iorq_n = 1'b0;
			wr_n = 1'b0;
			exp_pulse = (addr[7:0] == PORT_FD) && !addr[15] && !m_lock;
			pulses_before = pulse_cnt;
			model_write(addr, data);
			repeat (n) @(negedge zclk);
			iorq_n = 1'b1;
			wr_n = 1'b1;
			repeat (3) @(negedge zclk);	// a and din stay put, register loads meanwhile
			check_state(name);
			check_val({name, " pulses"}, wide_t'(exp_pulse), wide_t'(pulse_cnt - pulses_before));
		end
	endtask

	task automatic bus_read(input string name, input logic [15:0] addr);
		int n;
		begin
			n = pick_hold();
			@(negedge zclk);
			a = addr;
			iorq_n = 1'b0;
			rd_n = 1'b0;
			@(posedge zclk);
			check_val({name, " dout"}, wide_t'(exp_read(addr)), wide_t'(dout));
			check_val({name, " porthit"}, wide_t'(exp_hit(addr)), wide_t'(porthit));
			check_val({name, " external"}, wide_t'(addr[7:0] == PORT_FD && addr[15]),
				wide_t'(external_port));
			check_val({name, " dataout"},
				wide_t'(exp_hit(addr) && !(addr[7:0] == PORT_FD && addr[15])), wide_t'(dataout));
			repeat (n) @(negedge zclk);
			iorq_n = 1'b1;
			rd_n = 1'b1;
			repeat (2) @(negedge zclk);
			check_val({name, " dataout idle"}, wide_t'(1'b0), wide_t'(dataout));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	initial
	begin
		#(BUS_CYCLES * CLKS_PER_CYCLE * CLK_PERIOD);
		$display("timeout: the test sequence did not finish in time");
		fail_stop();
	end

	initial
	begin
		logic [7:0] rb;
		rst_n = 1'b0;
		a = 16'h0000;
		din = 8'h00;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		keys_in = 5'h1F;
		tape_read = 1'b0;
		dma_act = 1'b0;
		ramnroms = 8'h00;
		dos7ffds = 8'h00;
		m_xt = '0;
		m_xt.vpage = 8'h05;
		m_xt.palsel = 4'hF;
		m_xt.hint_beg = HINT_VAL;
		m_xt.im2vect = 8'hFF;
		m_page = '0;
		m_border = 8'h00;
		m_lock = 1'b0;
		repeat (10) @(negedge zclk);
		rst_n = 1'b1;

		// reset defaults
		@(negedge zclk);
		check_state("reset");
		bus_read("reset be_a", 16'h0ABE);

		// every extension sub-address, twice over
		for (int pass = 0; pass < 2; pass++)
			for (int i = 0; i < 15; i++)
				bus_write("xt_field", {XT_LIST[i], PORT_XT}, rand_byte(), 0);

		// border and keyboard
		bus_write("border fe", 16'h00FE, 8'hA5, 0);
		bus_write("border xt", {XT_BORDER, PORT_XT}, 8'h3C, 0);
		rb = rand_byte();
		keys_in = rb[4:0];
		tape_read = rb[5];
		bus_read("fe read", 16'h7FFE);

		// 7FFD paging with a long bus cycle
		bus_write("p7ffd long", 16'h7FFD, 8'hDB, 12);
		ramnroms = rand_byte();
		dos7ffds = rand_byte();
		bus_read("be_8", 16'h08BE);
		bus_read("be_9", 16'h09BE);
		bus_read("be_a", 16'h0ABE);

		// 7FFD lock in 128K mode
		bus_write("eff7 a12 set", 16'h1FF7, 8'hFF, 0);	// no write with a12 high
		bus_write("eff7", 16'hEFF7, 8'h0C, 0);
		bus_write("p7ffd lock", 16'h7FFD, 8'h2E, 0);
		bus_write("p7ffd locked", 16'h7FFD, 8'h11, 0);
		bus_read("be_b", 16'h0BBE);

		// bus claim and shadow mode
		bus_read("ay fffd", 16'hFFFD);
		bus_read("unused", 16'h1234);
		dma_act = 1'b1;
		bus_read("xt stat", {XT_STAT, PORT_XT});
		bus_read("xt other", 16'h05AF);
		bus_read("bf off", 16'h00BF);
		bus_read("f7 a8 clr", 16'hEEF7);
		bus_write("bf on", 16'h00BF, 8'h01, 0);
		bus_read("bf on", 16'h00BF);
		bus_read("shadow a8 clr", 16'hEEF7);
		bus_read("shadow a8 set", 16'hEFF7);

		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- vlog.f
zports_pkg.sv
bus_strobe.sv
port_decode.sv
xt_regs.sv
pager_regs.sv
read_mux.sv
zports_top.sv
tb_zports.sv

//--- run_sim.sh
#!/bin/sh
# build and run the port block testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module tb_zports -o sim_zports &&
	out=$(./obj_dir/sim_zports) ; echo "$out" ;
echo "$out" | grep -q "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }
